//--- src/note_pkg.sv
// Note tuner shared constants: widths, note frequencies, melodies and display codes
package note_pkg;

    // ------------------------------------------------------------------------
    // Sample path and period measurement
    // ------------------------------------------------------------------------

    localparam int              W_SAMPLE  = 16;
    localparam logic [15:0]     THRESHOLD = 16'h1100;   // Rising crossing level
    localparam int              W_DIST    = 20;         // Enough for C at 50 MHz

    // ------------------------------------------------------------------------
    // Notes
    // ------------------------------------------------------------------------

    localparam int N_NOTES = 12;

    typedef logic [N_NOTES - 1:0] note_t;   // One-hot, C on top, zero is no note

    // Semitone index, C first
    typedef enum logic [3:0]
    {
        NOTE_C, NOTE_CS, NOTE_D, NOTE_DS, NOTE_E, NOTE_F,
        NOTE_FS, NOTE_G, NOTE_GS, NOTE_A, NOTE_AS, NOTE_B
    } note_idx_t;

    // Frequency in Hz times 100, lowest octave checked
    localparam logic [18:0] FREQ_100 [N_NOTES] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    localparam int N_OCTAVES    = 3;    // x1, x2, x4
    localparam int TOL_LOW_PCT  = 98;
    localparam int TOL_HIGH_PCT = 102;

    // One-hot code of a semitone index
    function automatic note_t note_onehot(input int idx);
        note_onehot = note_t'(1) << (N_NOTES - 1 - idx);
    endfunction

    // ------------------------------------------------------------------------
    // Melodies
    // ------------------------------------------------------------------------

    localparam int N_MELODIES = 3;
    localparam int MELODY_LEN = 15;
    localparam int W_STATE    = 4;

    typedef logic [W_STATE - 1:0] melody_state_t;

    localparam melody_state_t RECOGNIZED = 4'hf;

    // Bf is AS, Ef is DS, Af is GS
    localparam note_idx_t MELODY [N_MELODIES][MELODY_LEN] = '{
        // Story of love
        '{NOTE_AS, NOTE_D, NOTE_AS, NOTE_D, NOTE_DS, NOTE_D, NOTE_C, NOTE_A,
          NOTE_C, NOTE_A, NOTE_C, NOTE_D, NOTE_C, NOTE_AS, NOTE_G},
        // Godfather
        '{NOTE_G, NOTE_C, NOTE_DS, NOTE_D, NOTE_C, NOTE_DS, NOTE_C, NOTE_D,
          NOTE_C, NOTE_GS, NOTE_AS, NOTE_G, NOTE_C, NOTE_DS, NOTE_D},
        // Gangsters song
        '{NOTE_E, NOTE_F, NOTE_E, NOTE_A, NOTE_B, NOTE_C, NOTE_D, NOTE_C,
          NOTE_B, NOTE_C, NOTE_G, NOTE_C, NOTE_A, NOTE_C, NOTE_A}
    };

    // ------------------------------------------------------------------------
    // Seven segment display, abcdefgh active low
    // ------------------------------------------------------------------------

    localparam int N_DIGITS = 4;

    localparam logic [7:0] SEG_BLANK = 8'b1111_1111;

    localparam logic [7:0] SEG_NOTE [N_NOTES] = '{
        8'b01100011, 8'b01100010, 8'b10000101, 8'b10000100,   // C  C# D  D#
        8'b01100001, 8'b01110001, 8'b01110000, 8'b01000011,   // E  F  F# G
        8'b01000010, 8'b00010001, 8'b00010000, 8'b11000001    // G# A  A# B
    };

    localparam logic [7:0] SEG_HEX [16] = '{
        8'b00000011, 8'b10011111, 8'b00100101, 8'b00001101,
        8'b10011001, 8'b01001001, 8'b01000001, 8'b00011111,
        8'b00000001, 8'b00011001, 8'b00010001, 8'b11000001,
        8'b01100011, 8'b10000101, 8'b01100001, 8'b00111001   // f is upper o
    };

endpackage

//--- src/period_meter.sv
// Period meter: measures clocks between rising threshold crossings of the samples
`timescale 1ns/10ps

module period_meter
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic [note_pkg::W_SAMPLE - 1:0]   i_sample,
    output logic [note_pkg::W_DIST - 1:0]     o_distance
);

    logic [note_pkg::W_SAMPLE - 1:0] prev_sample;
    logic [note_pkg::W_DIST - 1:0]   counter;

    wire crossing = (i_sample >= note_pkg::THRESHOLD)
                  & (prev_sample < note_pkg::THRESHOLD);

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            prev_sample <= '0;
            counter     <= '0;
            o_distance  <= '0;
        end
        else
        begin
            prev_sample <= i_sample;

            if (crossing)
            begin
                o_distance <= counter;   // Period minus one
                counter    <= '0;
            end
            else if (counter != '1)
                counter <= counter + 1'b1;   // Saturate on silence
        end

    // A saturated counter holds until the next crossing
    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        (&counter && !crossing) |=> &counter);

endmodule

//--- src/note_classifier.sv
// Note classifier: maps a measured period to a semitone over three octaves
`timescale 1ns/10ps

module note_classifier
#(
    parameter int CLK_HZ = 50_000_000
)
(
    input  logic [note_pkg::W_DIST - 1:0] i_distance,
    output note_pkg::note_t               o_note
);

    // Period bound for a note and octave, pct of the nominal period
    function automatic longint bound(input int note, input int oct, input int pct);
        return longint'(CLK_HZ) * pct / (longint'(note_pkg::FREQ_100[note]) << oct);
    endfunction

    wire [63:0] distance = 64'(i_distance);

    for (genvar n = 0; n < note_pkg::N_NOTES; n++)
    begin : g_note
        logic [note_pkg::N_OCTAVES - 1:0] hit;

        for (genvar k = 0; k < note_pkg::N_OCTAVES; k++)
        begin : g_oct
            localparam longint LOW  = bound(n, k, note_pkg::TOL_LOW_PCT);
            localparam longint HIGH = bound(n, k, note_pkg::TOL_HIGH_PCT);

            // Strictly inside the window
            assign hit[k] = (distance > 64'(LOW)) & (distance < 64'(HIGH));
        end

        assign o_note[note_pkg::N_NOTES - 1 - n] = |hit;
    end

    // Windows of different notes never overlap
    always_comb
        a_onehot: assert ($onehot0(o_note));

endmodule

//--- src/note_stabilizer.sv
// Note stabilizer: releases a note only after it has held steady for a while
`timescale 1ns/10ps

module note_stabilizer
#(
    parameter int HOLD_BITS = 18
)
(
    input  logic            clk,
    input  logic            reset,
    input  note_pkg::note_t i_note,
    output note_pkg::note_t o_stable_note
);

    note_pkg::note_t        d_note;     // One clock behind i_note
    logic [HOLD_BITS - 1:0] hold_cnt;

    always_ff @(posedge clk or posedge reset)
        if (reset)
            d_note <= '0;
        else
            d_note <= i_note;

    always_ff @(posedge clk or posedge reset)
        if (reset)
            hold_cnt <= '0;
        else if (i_note == d_note)
            hold_cnt <= hold_cnt + 1'b1;
        else
            hold_cnt <= '0;   // Restart on any change

    always_ff @(posedge clk or posedge reset)
        if (reset)
            o_stable_note <= '0;
        else if (&hold_cnt)
            o_stable_note <= d_note;

endmodule

//--- src/melody_recognizer.sv
// Melody recognizer: tracks progress through one stored melody
`timescale 1ns/10ps

module melody_recognizer
#(
    parameter int MELODY_ID = 0
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  note_pkg::note_t         i_stable_note,
    output note_pkg::melody_state_t o_state
);

    note_pkg::note_t expected;

    // Next note to wait for, none once complete
    always_comb
    begin
        expected = '0;
        if (o_state < note_pkg::MELODY_LEN)
            expected = note_pkg::note_onehot(note_pkg::MELODY[MELODY_ID][o_state]);
    end

    always_ff @(posedge clk or posedge reset)
        if (reset)
            o_state <= '0;
        else if (o_state != note_pkg::RECOGNIZED && i_stable_note == expected)
        begin
            if (o_state == note_pkg::W_STATE'(note_pkg::MELODY_LEN - 1))
                o_state <= note_pkg::RECOGNIZED;
            else
                o_state <= o_state + 1'b1;
        end

    // A recognized melody stays recognized until reset
    a_stay_recognized: assert property (@(posedge clk) disable iff (reset)
        o_state == note_pkg::RECOGNIZED |=> o_state == note_pkg::RECOGNIZED);

endmodule

//--- src/segment_scanner.sv
// Segment scanner: multiplexes note and melody progress onto four digits and LEDs
`timescale 1ns/10ps

module segment_scanner
#(
    parameter int SCAN_BITS = 16
)
(
    input  logic                            clk,
    input  logic                            reset,
    input  note_pkg::note_t                 i_stable_note,
    input  note_pkg::melody_state_t         i_states [note_pkg::N_MELODIES],
    output logic [7:0]                      o_abcdefgh,
    output logic [note_pkg::N_DIGITS - 1:0] o_digit,
    output logic [note_pkg::N_MELODIES:0]   o_led
);

    // ------------------------------------------------------------------------
    // Scan timing
    // ------------------------------------------------------------------------

    logic [SCAN_BITS - 1:0] scan_cnt;

    always_ff @(posedge clk or posedge reset)
        if (reset)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;

    wire scan_en = &scan_cnt;

    logic [$clog2(note_pkg::N_DIGITS) - 1:0] digit_idx_r;
    wire  [$clog2(note_pkg::N_DIGITS) - 1:0] digit_idx = digit_idx_r + 1'b1;

    // ------------------------------------------------------------------------
    // Segment selection
    // ------------------------------------------------------------------------

    logic [7:0] seg_next;

    always_comb
    begin
        seg_next = note_pkg::SEG_BLANK;
        if (digit_idx == note_pkg::N_DIGITS - 1)
        begin
            for (int i = 0; i < note_pkg::N_NOTES; i++)
                if (i_stable_note == note_pkg::note_onehot(i))
                    seg_next = note_pkg::SEG_NOTE[i];
        end
        else if (digit_idx < note_pkg::N_MELODIES)
            seg_next = note_pkg::SEG_HEX[i_states[note_pkg::N_MELODIES - 1 - digit_idx]];
    end

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            digit_idx_r <= '0;
            o_digit     <= '1;                     // All digits off
            o_abcdefgh  <= note_pkg::SEG_BLANK;
        end
        else if (scan_en)
        begin
            digit_idx_r <= digit_idx;
            o_digit     <= ~(note_pkg::N_DIGITS'(1) << digit_idx);   // Active low
            o_abcdefgh  <= seg_next;
        end

    // ------------------------------------------------------------------------
    // LEDs
    // ------------------------------------------------------------------------

    logic [note_pkg::N_MELODIES:0] led_next;

    always_comb
    begin
        for (int i = 0; i < note_pkg::N_MELODIES; i++)
            led_next[note_pkg::N_MELODIES - i] = (i_states[i] == note_pkg::RECOGNIZED);
        led_next[0] = &led_next[note_pkg::N_MELODIES:1];   // All recognized
    end

    always_ff @(posedge clk or posedge reset)
        if (reset)
            o_led <= '0;
        else
            o_led <= led_next;

endmodule

//--- src/note_tuner_top.sv
// Note tuner top: sample period to stable note, melody tracking and display
`timescale 1ns/10ps

module note_tuner_top
#(
    parameter int CLK_HZ    = 50_000_000,
    parameter int HOLD_BITS = 18,
    parameter int SCAN_BITS = 16
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic [note_pkg::W_SAMPLE - 1:0]   i_sample,
    output logic [7:0]                        o_abcdefgh,
    output logic [note_pkg::N_DIGITS - 1:0]   o_digit,
    output logic [note_pkg::N_MELODIES:0]     o_led
);

    logic [note_pkg::W_DIST - 1:0] distance;
    note_pkg::note_t               raw_note;
    note_pkg::note_t               stable_note;
    note_pkg::melody_state_t       states [note_pkg::N_MELODIES];

    // ------------------------------------------------------------------------
    // Note detection
    // ------------------------------------------------------------------------

    period_meter u_period_meter
    (
        .clk        (clk),
        .reset      (reset),
        .i_sample   (i_sample),
        .o_distance (distance)
    );

    note_classifier #(.CLK_HZ(CLK_HZ)) u_note_classifier
    (
        .i_distance (distance),
        .o_note     (raw_note)
    );

    note_stabilizer #(.HOLD_BITS(HOLD_BITS)) u_note_stabilizer
    (
        .clk           (clk),
        .reset         (reset),
        .i_note        (raw_note),
        .o_stable_note (stable_note)
    );

    // ------------------------------------------------------------------------
    // One recognizer per stored melody, then the display
    // ------------------------------------------------------------------------

    for (genvar m = 0; m < note_pkg::N_MELODIES; m++)
    begin : g_melody
        melody_recognizer #(.MELODY_ID(m)) u_melody_recognizer
        (
            .clk           (clk),
            .reset         (reset),
            .i_stable_note (stable_note),
            .o_state       (states[m])
        );
    end

    segment_scanner #(.SCAN_BITS(SCAN_BITS)) u_segment_scanner
    (
        .clk           (clk),
        .reset         (reset),
        .i_stable_note (stable_note),
        .i_states      (states),
        .o_abcdefgh    (o_abcdefgh),
        .o_digit       (o_digit),
        .o_led         (o_led)
    );

endmodule

//--- testbench/note_checker.sv
// Output checker: reads the multiplexed digits and LEDs and compares them with expected values
`timescale 1ns/10ps

module note_checker
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [7:0]                      i_abcdefgh,
    input  logic [note_pkg::N_DIGITS - 1:0] i_digit,
    input  logic [note_pkg::N_MELODIES:0]   i_led,
    input  logic                            i_check,
    input  int                              i_row,
    input  logic [7:0]                      i_exp_note_seg,
    input  note_pkg::melody_state_t         i_exp_states [note_pkg::N_MELODIES],
    input  logic [note_pkg::N_MELODIES:0]   i_exp_led,
    output int                              o_checks,
    output int                              o_fails
);

    logic [7:0]                      seg_seen [note_pkg::N_DIGITS];
    logic [note_pkg::N_DIGITS - 1:0] seen;
    int                              errors;
    string                           label;

    task automatic compare_value(input string what, input logic [7:0] got,
                                 input logic [7:0] expected);
        if (got !== expected)
        begin
            $display("** Error at %0t: %s %s is %b, expected %b",
                     $time, label, what, got, expected);
            errors++;
        end
    endtask

    // Waits until every digit has been selected once
    task automatic capture_digits();
        seen = '0;
        while (seen != '1)
        begin
            @(negedge clk);
            for (int d = 0; d < note_pkg::N_DIGITS; d++)
                if (i_digit == ~(note_pkg::N_DIGITS'(1) << d))
                begin
                    seg_seen[d] = i_abcdefgh;
                    seen[d]     = 1'b1;
                end
        end
    endtask

    task automatic report_result();
        o_checks++;
        if (errors == 0)
            $display("%s: ok", label);
        else
        begin
            o_fails++;
            $display("%s: %0d mismatches", label, errors);
        end
    endtask

    initial
    begin
        o_checks = 0;
        o_fails  = 0;
        wait (reset === 1'b1);
        @(negedge clk);
        errors = 0;
        label  = "reset";
        compare_value("LEDs", 8'(i_led), 8'h00);
        compare_value("digit select", 8'(i_digit), 8'({note_pkg::N_DIGITS{1'b1}}));
        compare_value("segments", i_abcdefgh, note_pkg::SEG_BLANK);
        report_result();

        forever
        begin
            @(negedge clk);
            if (i_check)
            begin
                errors = 0;
                label  = $sformatf("row %0d", i_row);
                capture_digits();
                compare_value("digit 3", seg_seen[note_pkg::N_DIGITS - 1], i_exp_note_seg);
                // Leftmost melody digit belongs to melody 0
                for (int d = 0; d < note_pkg::N_MELODIES; d++)
                    compare_value($sformatf("digit %0d", d), seg_seen[d],
                        note_pkg::SEG_HEX[i_exp_states[note_pkg::N_MELODIES - 1 - d]]);
                compare_value("LEDs", 8'(i_led), 8'(i_exp_led));
                report_result();
            end
        end
    end

endmodule

//--- testbench/tb_note_tuner.sv
// Note tuner testbench that plays melodies, stray tones and a tuning sweep into the DUT
`timescale 1ns/10ps

module tb_note_tuner;

    localparam int CLK_HZ     = 1_000_000;
    localparam int HOLD_BITS  = 10;
    localparam int SCAN_BITS  = 2;
    localparam int MAX_ROWS   = 96;
    localparam int OFF        = -1;     // Note column for a tone outside every window
    localparam int OFF_PERIOD = 695;    // Between the F and F# windows at x4

    // Stray tones that occur in no melody
    localparam int STRAY_NOTE [note_pkg::N_MELODIES] = '{1, 6, 6};   // C#, F#, F#
    localparam int STRAY_MULT [note_pkg::N_MELODIES] = '{4, 2, 4};

    logic                            clk;
    logic                            reset;
    logic [note_pkg::W_SAMPLE - 1:0] i_sample;
    logic [7:0]                      o_abcdefgh;
    logic [note_pkg::N_DIGITS - 1:0] o_digit;
    logic [note_pkg::N_MELODIES:0]   o_led;

    // ------------------------------------------------------------------------
    // Stimulus table with expected columns
    // ------------------------------------------------------------------------

    int                            n_rows;
    int                            row_period [MAX_ROWS];   // Clocks per tone period
    int                            row_count  [MAX_ROWS];   // Tone periods played
    logic [7:0]                    row_seg    [MAX_ROWS];
    note_pkg::melody_state_t       row_states [MAX_ROWS][note_pkg::N_MELODIES];
    logic [note_pkg::N_MELODIES:0] row_led    [MAX_ROWS];
    note_pkg::melody_state_t       progress   [note_pkg::N_MELODIES];

    logic                          check_req;
    int                            check_row;
    logic [7:0]                    exp_seg;
    note_pkg::melody_state_t       exp_states [note_pkg::N_MELODIES];
    logic [note_pkg::N_MELODIES:0] exp_led;
    int                            n_checks;
    int                            n_fails;
    int                            total_cycles;
    int                            cycle_count;
    int                            cycle_limit = 0;

    note_tuner_top #(.CLK_HZ(CLK_HZ), .HOLD_BITS(HOLD_BITS), .SCAN_BITS(SCAN_BITS)) uut
    (
        .clk        (clk),
        .reset      (reset),
        .i_sample   (i_sample),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit),
        .o_led      (o_led)
    );

    note_checker u_checker
    (
        .clk            (clk),
        .reset          (reset),
        .i_abcdefgh     (o_abcdefgh),
        .i_digit        (o_digit),
        .i_led          (o_led),
        .i_check        (check_req),
        .i_row          (check_row),
        .i_exp_note_seg (exp_seg),
        .i_exp_states   (exp_states),
        .i_exp_led      (exp_led),
        .o_checks       (n_checks),
        .o_fails        (n_fails)
    );

    // Appends a row with its expected display from the melody rules
    task automatic add_row(input int note, input int mult);
        longint freq;
        if (note == OFF)
            row_period[n_rows] = OFF_PERIOD;
        else
        begin
            freq = longint'(note_pkg::FREQ_100[note]) * mult;
            row_period[n_rows] = int'((longint'(CLK_HZ) * 100 + freq / 2) / freq);
        end
        row_count[n_rows] = (2 ** HOLD_BITS + row_period[n_rows] - 1) / row_period[n_rows] + 4;
        row_seg[n_rows]   = (note == OFF) ? note_pkg::SEG_BLANK : note_pkg::SEG_NOTE[note];
        row_led[n_rows]   = '0;
        row_led[n_rows][0] = 1'b1;
        for (int m = 0; m < note_pkg::N_MELODIES; m++)
        begin
            if (note != OFF && progress[m] != note_pkg::RECOGNIZED
                && int'(note_pkg::MELODY[m][progress[m]]) == note)
                progress[m] = progress[m] + 1'b1;   // Entry 14 steps to f
            row_states[n_rows][m] = progress[m];
            row_led[n_rows][note_pkg::N_MELODIES - m] = (progress[m] == note_pkg::RECOGNIZED);
            row_led[n_rows][0] &= (progress[m] == note_pkg::RECOGNIZED);
        end
        n_rows++;
    endtask

    function automatic logic [note_pkg::W_SAMPLE - 1:0] sample_level(input logic high);
        if (high)
            return note_pkg::THRESHOLD + 16'($urandom % 32'h4000) + 16'd1;
        return note_pkg::THRESHOLD - 16'($urandom % 32'h1000) - 16'd1;
    endfunction

    task automatic play_half(input logic high, input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            i_sample  = sample_level(high);
            check_req = 1'b0;
        end
    endtask

    task automatic request_check(input int r);
        check_row = r;
        exp_seg   = row_seg[r];
        exp_led   = row_led[r];
        for (int m = 0; m < note_pkg::N_MELODIES; m++)
            exp_states[m] = row_states[r][m];
        check_req = 1'b1;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------

    initial
    begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(97307));
        reset     = 1'b1;
        i_sample  = '0;
        check_req = 1'b0;
        check_row = 0;
        exp_seg   = note_pkg::SEG_BLANK;
        exp_led   = '0;
        n_rows    = 0;
        for (int m = 0; m < note_pkg::N_MELODIES; m++)
        begin
            exp_states[m] = '0;
            progress[m]   = '0;
        end

        // Melodies at x4 with strays inside each one
        for (int m = 0; m < note_pkg::N_MELODIES; m++)
            for (int k = 0; k < note_pkg::MELODY_LEN; k++)
            begin
                add_row(int'(note_pkg::MELODY[m][k]), 4);
                if (k == 4)
                    add_row(STRAY_NOTE[m], STRAY_MULT[m]);
                if (k == 11)
                    add_row(OFF, 1);
            end
        for (int mult = 1; mult <= 4; mult *= 2)
            for (int n = 0; n < note_pkg::N_NOTES; n++)
                add_row(n, mult);
        add_row(OFF, 1);

        total_cycles = 0;
        for (int r = 0; r < n_rows; r++)
            total_cycles += row_count[r] * row_period[r];
        cycle_limit = total_cycles + total_cycles / 5;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // High half first so each crossing opens a period
        for (int r = 0; r < n_rows; r++)
        begin
            for (int p = 0; p < row_count[r]; p++)
            begin
                play_half(1'b1, row_period[r] / 2);
                play_half(1'b0, row_period[r] - row_period[r] / 2);
            end
            request_check(r);
        end
        play_half(1'b0, 1);

        while (n_checks < n_rows + 1)
            @(posedge clk);
        $display("Checks %0d, passed %0d, failed %0d", n_checks, n_checks - n_fails, n_fails);
        if (n_fails == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- compile.f
src/note_pkg.sv
src/period_meter.sv
src/note_classifier.sv
src/note_stabilizer.sv
src/melody_recognizer.sv
src/segment_scanner.sv
src/note_tuner_top.sv
testbench/note_checker.sv
testbench/tb_note_tuner.sv

//--- Makefile
# Verilator build and run for the note tuner

VERILATOR ?= verilator
TOP       ?= tb_note_tuner
RTL_TOP   ?= note_tuner_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
RTL_FILES ?= $(shell grep '^src/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
